// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int REG_BITS = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } res_src_e;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [REG_BITS-1:0] rs2;
        logic [REG_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [REG_BITS-1:0] rd;
        logic [6:0]          opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]         imm;
        logic [REG_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [REG_BITS-1:0] rd;
        logic [6:0]          opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]          imm_hi;
        logic [REG_BITS-1:0] rs2;
        logic [REG_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          imm_lo;
        logic [6:0]          opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                imm12;
        logic [5:0]          imm10_5;
        logic [REG_BITS-1:0] rs2;
        logic [REG_BITS-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm4_1;
        logic                imm11;
        logic [6:0]          opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]         imm;
        logic [REG_BITS-1:0] rd;
        logic [6:0]          opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                imm20;
        logic [9:0]          imm10_1;
        logic                imm11;
        logic [7:0]          imm19_12;
        logic [REG_BITS-1:0] rd;
        logic [6:0]          opcode;
    } j_fmt_t;

    // one instruction word, seen through each base format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

// File: logic/rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if import rv_pkg::*; #(
    parameter int IADDR_BITS = 16
) ();

    logic                  valid;
    logic [IADDR_BITS-1:2] pc;
    logic [REG_BITS-1:0]   rs1;
    logic [REG_BITS-1:0]   rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_BITS-1:0]   rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    res_src_e              res_src;
    logic                  reg_write;
    logic                  op1_pc;  // first operand is the pc instead of rs1.
    logic                  op2_imm; // second operand is the immediate instead of rs2.
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jal;
    logic [2:0]            funct3;

    modport dec (
        output valid, pc, rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op, res_src,
               reg_write, op1_pc, op2_imm, is_store, is_branch, is_jal, funct3
    );

    modport exe (
        input  valid, pc, rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op, res_src,
               reg_write, op1_pc, op2_imm, is_store, is_branch, is_jal, funct3
    );

endinterface

// File: logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
    parameter int              IADDR_BITS = 16,
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  logic                  i_redirect,
    input  logic [IADDR_BITS-1:2] i_redirect_pc,
    input  logic                  i_instr_ack,
    input  logic [XLEN-1:0]       i_instr_data,
    output logic                  o_instr_req,
    output logic [IADDR_BITS-1:2] o_instr_addr,
    output instr_t                o_instr,
    output logic [IADDR_BITS-1:2] o_pc,
    output logic                  o_valid
);

    logic [IADDR_BITS-1:2] redirect_pc_q; // target kept while a stale request completes.
    logic                  drop;          // the request in flight belongs to the old path.
    logic                  accept;

    assign accept = i_instr_ack && !drop && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_instr_req  <= 1'b1;
            o_instr_addr <= RESET_ADDR[IADDR_BITS-1:2];
            o_valid      <= 1'b0;
            drop         <= 1'b0;
        end else begin
            // a word acked during a stall is thrown away and fetched again afterwards.
            o_instr_req <= !(i_instr_ack && i_stall);
            if (i_instr_ack) begin
                drop <= 1'b0;
                if (i_redirect) begin
                    o_instr_addr <= i_redirect_pc;
                end else if (drop) begin
                    o_instr_addr <= redirect_pc_q;
                end else if (!i_stall) begin
                    o_instr_addr <= o_instr_addr + 1'b1;
                end
            end else if (i_redirect) begin
                drop <= 1'b1;
            end
            if (i_flush) begin
                o_valid <= 1'b0;
            end else if (!i_stall) begin
                o_valid <= accept;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_redirect) redirect_pc_q <= i_redirect_pc;
        if (accept) begin
            o_instr <= i_instr_data;
            o_pc    <= o_instr_addr;
        end
    end

endmodule

// File: logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; #(
    parameter int IADDR_BITS = 16
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  instr_t                i_instr,
    input  logic [IADDR_BITS-1:2] i_pc,
    input  logic                  i_valid,
    input  logic [XLEN-1:0]       i_rs1_data,
    input  logic [XLEN-1:0]       i_rs2_data,
    output logic [REG_BITS-1:0]   o_rs1,
    output logic [REG_BITS-1:0]   o_rs2,
    output logic                  o_illegal_instr,
    rv_decode_if.dec              dec
);

    logic [6:0]      opcode;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    res_src_e        res_src;
    logic            supported;
    logic            reg_write;
    logic            op1_pc;
    logic            op2_imm;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;

    assign opcode = i_instr.r.opcode;
    assign o_rs1  = (opcode == OPC_LUI) ? '0 : i_instr.r.rs1; // lui adds its immediate to x0.
    assign o_rs2  = i_instr.r.rs2;

    always_comb begin
        case (i_instr.r.funct3)
            3'b000:  alu_op = (opcode == OPC_OP && i_instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = i_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        // addresses, targets and lui all go through the adder.
        if (opcode != OPC_OP && opcode != OPC_OP_IMM) alu_op = ALU_ADD;
    end

    always_comb begin
        imm       = {{(XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
        res_src   = RES_ALU;
        supported = 1'b1;
        reg_write = 1'b0;
        op1_pc    = 1'b0;
        op2_imm   = 1'b1;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                op2_imm   = 1'b0;
            end
            OPC_OP_IMM: reg_write = 1'b1;
            OPC_LUI: begin
                reg_write = 1'b1;
                imm       = {i_instr.u.imm, 12'b0};
            end
            OPC_LOAD: begin
                reg_write = 1'b1;
                res_src   = RES_MEM;
                supported = (i_instr.i.funct3 == 3'b010); // lw only.
            end
            OPC_STORE: begin
                is_store  = 1'b1;
                supported = (i_instr.s.funct3 == 3'b010);
                imm       = {{(XLEN-12){i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                op1_pc    = 1'b1;
                supported = !i_instr.b.funct3[1]; // beq, bne, blt, bge.
                imm       = {{(XLEN-13){i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                             i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
            end
            OPC_JAL: begin
                is_jal    = 1'b1;
                reg_write = 1'b1;
                op1_pc    = 1'b1;
                res_src   = RES_PC4;
                imm       = {{(XLEN-21){i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                             i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    // a stalled word is decoded again next cycle, so it reports nothing now.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            dec.valid       <= 1'b0;
            o_illegal_instr <= 1'b0;
        end else begin
            dec.valid       <= i_valid && supported && !i_stall && !i_flush;
            o_illegal_instr <= i_valid && !supported && !i_stall && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        dec.pc        <= i_pc;
        dec.rs1       <= o_rs1;
        dec.rs2       <= o_rs2;
        dec.rs1_data  <= i_rs1_data;
        dec.rs2_data  <= i_rs2_data;
        dec.rd        <= i_instr.r.rd;
        dec.imm       <= imm;
        dec.alu_op    <= alu_op;
        dec.res_src   <= res_src;
        dec.reg_write <= reg_write;
        dec.op1_pc    <= op1_pc;
        dec.op2_imm   <= op2_imm;
        dec.is_store  <= is_store;
        dec.is_branch <= is_branch;
        dec.is_jal    <= is_jal;
        dec.funct3    <= i_instr.r.funct3;
    end

endmodule

// File: logic/rv_regs.sv
`timescale 1ns/1ps

module rv_regs import rv_pkg::*; (
    input  logic                i_clk,
    input  logic [REG_BITS-1:0] i_rs1,
    input  logic [REG_BITS-1:0] i_rs2,
    input  logic [REG_BITS-1:0] i_rd,
    input  logic                i_write,
    input  logic [XLEN-1:0]     i_data,
    output logic [XLEN-1:0]     o_data1,
    output logic [XLEN-1:0]     o_data2
);

    logic [XLEN-1:0] regs [1:2**REG_BITS-1]; // x0 has no storage.

    function automatic logic [XLEN-1:0] read_port(input logic [REG_BITS-1:0] rs);
        if (rs == '0) return '0;
        if (i_write && i_rd == rs) return i_data; // write-through.
        return regs[rs];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_write && i_rd != '0) regs[i_rd] <= i_data;
    end

    always_comb begin
        o_data1 = read_port(i_rs1);
        o_data2 = read_port(i_rs2);
    end

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; #(
    parameter int IADDR_BITS = 16
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    rv_decode_if.exe              exe,
    input  logic [XLEN-1:0]       i_data_rdata,
    output logic                  o_data_req,
    output logic                  o_data_write,
    output logic [XLEN-1:0]       o_data_addr,
    output logic [XLEN-1:0]       o_data_wdata,
    output logic                  o_redirect,
    output logic [IADDR_BITS-1:2] o_redirect_pc,
    output logic [REG_BITS-1:0]   o_load_rd,
    output logic                  o_load_valid,
    output logic [REG_BITS-1:0]   o_wb_rd,
    output logic                  o_wb_write,
    output logic [XLEN-1:0]       o_wb_data
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] wb_result;
    res_src_e        wb_src;
    logic            eq;
    logic            lt;
    logic            taken;

    // the previous instruction sits in the write-back register and is forwarded from there.
    assign rs1_val = (o_wb_write && o_wb_rd == exe.rs1 && exe.rs1 != '0) ? o_wb_data
                                                                         : exe.rs1_data;
    assign rs2_val = (o_wb_write && o_wb_rd == exe.rs2 && exe.rs2 != '0) ? o_wb_data
                                                                         : exe.rs2_data;

    assign op1      = exe.op1_pc ? XLEN'({exe.pc, 2'b00}) : rs1_val;
    assign op2      = exe.op2_imm ? exe.imm : rs2_val;
    assign pc_plus4 = XLEN'({exe.pc + 1'b1, 2'b00});

    always_comb begin
        case (exe.alu_op)
            ALU_SUB:  alu_res = op1 - op2;
            ALU_AND:  alu_res = op1 & op2;
            ALU_OR:   alu_res = op1 | op2;
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SLT:  alu_res = XLEN'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_res = XLEN'(op1 < op2);
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SRL:  alu_res = op1 >> op2[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op1) >>> op2[4:0]);
            default:  alu_res = op1 + op2;
        endcase
    end

    assign eq    = (rs1_val == rs2_val);
    assign lt    = ($signed(rs1_val) < $signed(rs2_val));
    assign taken = exe.funct3[2] ? (lt ^ exe.funct3[0]) : (eq ^ exe.funct3[0]); // funct3[0] inverts.

    assign o_redirect    = exe.valid && (exe.is_jal || (exe.is_branch && taken));
    assign o_redirect_pc = alu_res[IADDR_BITS-1:2]; // pc plus immediate for branch and jal.

    assign o_load_valid = exe.valid && exe.res_src == RES_MEM;
    assign o_load_rd    = exe.rd;
    assign o_data_req   = o_load_valid || (exe.valid && exe.is_store);
    assign o_data_write = exe.is_store;
    assign o_data_addr  = alu_res;
    assign o_data_wdata = rs2_val;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_write <= 1'b0;
        end else begin
            o_wb_write <= exe.valid && exe.reg_write;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= exe.rd;
        wb_src    <= exe.res_src;
        wb_result <= (exe.res_src == RES_PC4) ? pc_plus4 : alu_res;
    end

    assign o_wb_data = (wb_src == RES_MEM) ? i_data_rdata : wb_result; // load data arrives now.

endmodule

// File: logic/rv_ctrl.sv
`timescale 1ns/1ps

module rv_ctrl import rv_pkg::*; (
    input  instr_t              i_instr,
    input  logic                i_valid,
    input  logic [REG_BITS-1:0] i_load_rd,
    input  logic                i_load_valid,
    input  logic                i_redirect,
    output logic                o_fetch_stall,
    output logic                o_decode_stall,
    output logic                o_decode_flush,
    output logic                o_fetch_flush
);

    logic load_use;

    // the word leaving fetch needs a register that a load in execute has not yet returned.
    assign load_use = i_valid && i_load_valid && i_load_rd != '0 &&
                      (i_instr.r.rs1 == i_load_rd || i_instr.r.rs2 == i_load_rd);

    assign o_fetch_stall  = load_use && !i_redirect; // a redirect wins over a stall.
    assign o_decode_stall = load_use && !i_redirect;
    assign o_fetch_flush  = i_redirect;
    assign o_decode_flush = i_redirect;

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter int              IADDR_BITS = 16,
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    output logic                  o_instr_req,
    output logic [IADDR_BITS-1:2] o_instr_addr,
    input  logic                  i_instr_ack,
    input  logic [XLEN-1:0]       i_instr_data,
    output logic                  o_data_req,
    output logic                  o_data_write,
    output logic [XLEN-1:0]       o_data_addr,
    output logic [XLEN-1:0]       o_data_wdata,
    input  logic [XLEN-1:0]       i_data_rdata,
    output logic                  o_illegal_instr
);

    instr_t                fetch_instr;
    logic [IADDR_BITS-1:2] fetch_pc;
    logic                  fetch_valid;
    logic                  fetch_stall;
    logic                  fetch_flush;
    logic                  decode_stall;
    logic                  decode_flush;
    logic [REG_BITS-1:0]   rs1;
    logic [REG_BITS-1:0]   rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  redirect;
    logic [IADDR_BITS-1:2] redirect_pc;
    logic [REG_BITS-1:0]   load_rd;
    logic                  load_valid;
    logic [REG_BITS-1:0]   wb_rd;
    logic                  wb_write;
    logic [XLEN-1:0]       wb_data;

    rv_decode_if #(.IADDR_BITS(IADDR_BITS)) dec_if ();

    rv_fetch #(
        .IADDR_BITS (IADDR_BITS),
        .RESET_ADDR (RESET_ADDR)
    ) u_fetch (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (fetch_stall),
        .i_flush       (fetch_flush),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_instr_ack   (i_instr_ack),
        .i_instr_data  (i_instr_data),
        .o_instr_req   (o_instr_req),
        .o_instr_addr  (o_instr_addr),
        .o_instr       (fetch_instr),
        .o_pc          (fetch_pc),
        .o_valid       (fetch_valid)
    );

    rv_decode #(.IADDR_BITS(IADDR_BITS)) u_decode (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_stall         (decode_stall),
        .i_flush         (decode_flush),
        .i_instr         (fetch_instr),
        .i_pc            (fetch_pc),
        .i_valid         (fetch_valid),
        .i_rs1_data      (rs1_data),
        .i_rs2_data      (rs2_data),
        .o_rs1           (rs1),
        .o_rs2           (rs2),
        .o_illegal_instr (o_illegal_instr),
        .dec             (dec_if.dec)
    );

    rv_regs u_regs (
        .i_clk   (i_clk),
        .i_rs1   (rs1),
        .i_rs2   (rs2),
        .i_rd    (wb_rd),
        .i_write (wb_write),
        .i_data  (wb_data),
        .o_data1 (rs1_data),
        .o_data2 (rs2_data)
    );

    rv_execute #(.IADDR_BITS(IADDR_BITS)) u_execute (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .exe           (dec_if.exe),
        .i_data_rdata  (i_data_rdata),
        .o_data_req    (o_data_req),
        .o_data_write  (o_data_write),
        .o_data_addr   (o_data_addr),
        .o_data_wdata  (o_data_wdata),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_load_rd     (load_rd),
        .o_load_valid  (load_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_write    (wb_write),
        .o_wb_data     (wb_data)
    );

    rv_ctrl u_ctrl (
        .i_instr        (fetch_instr),
        .i_valid        (fetch_valid),
        .i_load_rd      (load_rd),
        .i_load_valid   (load_valid),
        .i_redirect     (redirect),
        .o_fetch_stall  (fetch_stall),
        .o_decode_stall (decode_stall),
        .o_decode_flush (decode_flush),
        .o_fetch_flush  (fetch_flush)
    );

endmodule

// File: tb/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions import rv_pkg::*; #(
    parameter int IADDR_BITS = 16
) (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_instr_req,
    input logic [IADDR_BITS-1:2] i_instr_addr,
    input logic                  i_instr_ack,
    input logic                  i_data_req,
    input logic                  i_data_write,
    input logic [XLEN-1:0]       i_data_addr
);

    // an unanswered request keeps its address into the next cycle.
    req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        i_instr_req && !i_instr_ack |=> i_instr_req && $stable(i_instr_addr))
        else $error("instruction request dropped or moved before its ack");

    no_strobe_in_reset: assert property (@(posedge i_clk)
        i_reset && $past(i_reset) |-> !i_data_req)
        else $error("data strobe while in reset");

    // one strobe per load, so the same read never shows up twice in a row.
    single_load_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
        i_data_req && !i_data_write |=>
            !(i_data_req && !i_data_write && $stable(i_data_addr)))
        else $error("load strobe held for two cycles");

endmodule

bind rv_core rv_core_assertions #(.IADDR_BITS(IADDR_BITS)) u_assertions (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_instr_req  (o_instr_req),
    .i_instr_addr (o_instr_addr),
    .i_instr_ack  (i_instr_ack),
    .i_data_req   (o_data_req),
    .i_data_write (o_data_write),
    .i_data_addr  (o_data_addr)
);

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          IADDR_BITS = 16;
    localparam logic [31:0] RESET_ADDR = 32'h0;
    localparam logic [6:0]  IMM_OP     = 7'b0010011;
    localparam logic [6:0]  LOAD_OP    = 7'b0000011;
    localparam logic [31:0] A = 32'h8765_4000; // x1
    localparam logic [31:0] B = 32'hffff_fff9; // x2 holds minus seven.
    localparam logic [31:0] C = 32'd5;         // x3

    logic                  clk;
    logic                  reset;
    logic                  instr_req;
    logic [IADDR_BITS-1:2] instr_addr;
    logic                  instr_ack;
    logic [31:0]           instr_data;
    logic                  data_req;
    logic                  data_write;
    logic [31:0]           data_addr;
    logic [31:0]           data_wdata;
    logic [31:0]           data_rdata;
    logic                  illegal_instr;

    logic [31:0] imem [0:127];
    logic [31:0] dmem [0:127];
    logic [31:0] read_word;
    logic        read_pending;
    logic [11:0] next_addr;
    int unsigned wait_left;
    int unsigned prog_words;
    int unsigned illegal_count = 0;
    int unsigned value_errors  = 0;
    int unsigned other_errors  = 0;
    string       exp_name [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];

    rv_core #(
        .IADDR_BITS (IADDR_BITS),
        .RESET_ADDR (RESET_ADDR)
    ) u_rv_core (
        .i_clk           (clk),
        .i_reset         (reset),
        .o_instr_req     (instr_req),
        .o_instr_addr    (instr_addr),
        .i_instr_ack     (instr_ack),
        .i_instr_data    (instr_data),
        .o_data_req      (data_req),
        .o_data_write    (data_write),
        .o_data_addr     (data_addr),
        .o_data_wdata    (data_wdata),
        .i_data_rdata    (data_rdata),
        .o_illegal_instr (illegal_instr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw only.
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned idx);
        return 32'h5a00_0000 + idx * 32'h0001_0001;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_words] = word;
        prog_words++;
    endtask

    task automatic expect_store(input string name, input logic [4:0] rs, input logic [31:0] value);
        emit(s_type(next_addr, rs, 5'd0));
        exp_name.push_back(name);
        exp_addr.push_back({20'b0, next_addr});
        exp_data.push_back(value);
        next_addr += 12'd4;
    endtask

    // every ALU case writes x10 and stores it straight away.
    task automatic alu_case(input string name, input logic [31:0] instr, input logic [31:0] value);
        emit(instr);
        expect_store(name, 5'd10, value);
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s: expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_program();
        int unsigned jal_pc;
        for (int i = 0; i < 128; i++) begin
            imem[i] = i_type(12'(i), 5'd0, 3'd0, 5'd0, IMM_OP); // addi x0, x0, i.
            dmem[i] = fill_word(i);
        end
        prog_words = 0;
        next_addr  = 12'h100;
        emit(u_type(20'h87654, 5'd1));
        emit(i_type(-12'd7, 5'd0, 3'd0, 5'd2, IMM_OP));
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd3, IMM_OP));
        alu_case("add", r_type(7'h00, 2, 1, 3'd0, 10), A + B);
        alu_case("sub", r_type(7'h20, 2, 1, 3'd0, 10), A - B);
        alu_case("and", r_type(7'h00, 2, 1, 3'd7, 10), A & B);
        alu_case("or", r_type(7'h00, 2, 1, 3'd6, 10), A | B);
        alu_case("xor", r_type(7'h00, 2, 1, 3'd4, 10), A ^ B);
        alu_case("slt", r_type(7'h00, 3, 1, 3'd2, 10), 32'd1);
        alu_case("sltu", r_type(7'h00, 1, 3, 3'd3, 10), 32'd1);
        alu_case("sll", r_type(7'h00, 3, 1, 3'd1, 10), A << C);
        alu_case("srl", r_type(7'h00, 3, 1, 3'd5, 10), A >> C);
        alu_case("sra", r_type(7'h20, 3, 1, 3'd5, 10), $signed(A) >>> C);
        alu_case("addi", i_type(-12'd100, 1, 3'd0, 10, IMM_OP), A - 32'd100);
        alu_case("andi", i_type(12'h7f0, 2, 3'd7, 10, IMM_OP), B & 32'h7f0);
        alu_case("ori", i_type(12'h123, 1, 3'd6, 10, IMM_OP), A | 32'h123);
        alu_case("xori", i_type(-12'd1, 1, 3'd4, 10, IMM_OP), ~A);
        alu_case("slti", i_type(-12'd3, 3, 3'd2, 10, IMM_OP), 32'd0);
        alu_case("sltiu", i_type(-12'd1, 3, 3'd3, 10, IMM_OP), 32'd1);
        alu_case("slli", i_type(12'd3, 1, 3'd1, 10, IMM_OP), A << 3);
        alu_case("srli", i_type(12'd7, 1, 3'd5, 10, IMM_OP), A >> 7);
        alu_case("srai", i_type(12'h407, 1, 3'd5, 10, IMM_OP), $signed(A) >>> 7);
        alu_case("lui", u_type(20'habcde, 10), 32'habcde000);
        // in this dependent chain the sub reads x11 two instructions after it was written.
        emit(i_type(12'd1, 3, 3'd0, 11, IMM_OP));
        emit(r_type(7'h00, 11, 11, 3'd0, 11));
        emit(i_type(12'd3, 0, 3'd0, 13, IMM_OP));
        emit(r_type(7'h20, 13, 11, 3'd0, 11));
        emit(r_type(7'h00, 2, 11, 3'd4, 11));
        expect_store("chain", 11, ((C + 32'd1) * 32'd2 - 32'd3) ^ B);
        emit(i_type(12'h020, 0, 3'd2, 14, LOAD_OP));
        emit(r_type(7'h00, 3, 14, 3'd0, 15));
        expect_store("load use", 15, fill_word(8) + C);
        emit(b_type(13'd12, 3, 3, 3'd0)); // beq taken over two stores.
        emit(s_type(12'h1f0, 1, 0));
        emit(s_type(12'h1f4, 1, 0));
        emit(b_type(13'd12, 3, 3, 3'd1)); // bne falls through.
        emit(i_type(12'd33, 0, 3'd0, 16, IMM_OP));
        expect_store("bne fall through", 16, 32'd33);
        jal_pc = prog_words * 4;
        emit(j_type(21'd12, 17));
        emit(s_type(12'h1f8, 1, 0));
        emit(s_type(12'h1fc, 1, 0));
        expect_store("jal link", 17, RESET_ADDR + jal_pc + 32'd4);
        emit(32'h0000_007f);
        emit(i_type(12'd77, 0, 3'd0, 18, IMM_OP));
        expect_store("after illegal", 18, 32'd77);
        emit(j_type(21'd0, 0)); // spin here.
    endtask

    // instruction memory answers each request after 0 to 3 extra cycles.
    always @(posedge clk) begin
        logic in_reset;
        in_reset = reset;
        #1;
        if (in_reset || !instr_req) begin
            instr_ack = 1'b0;
            wait_left = $urandom_range(3, 0);
        end else if (wait_left == 0) begin
            instr_ack  = 1'b1;
            instr_data = imem[instr_addr[8:2]];
            wait_left  = $urandom_range(3, 0);
        end else begin
            instr_ack = 1'b0;
            wait_left--;
        end
    end

    always @(negedge clk) begin
        if (illegal_instr) illegal_count++;
        if (data_req && data_write) begin
            dmem[data_addr[8:2]] = data_wdata;
            store_addr.push_back(data_addr);
            store_data.push_back(data_wdata);
        end else if (data_req) begin
            read_word    = dmem[data_addr[8:2]];
            read_pending = 1'b1;
        end
    end

    always @(posedge clk) begin
        #1;
        if (read_pending) begin
            data_rdata   = read_word; // load data is valid in the cycle after the strobe.
            read_pending = 1'b0;
        end
    end

    initial begin
        int unsigned cycles;
        void'($urandom(32'hec7f));
        reset        = 1'b1;
        instr_ack    = 1'b0;
        instr_data   = '0;
        data_rdata   = '0;
        read_pending = 1'b0;
        wait_left    = 0;
        load_program();
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            assert (!data_req && !illegal_instr) else begin
                $display("data strobe or illegal pulse seen during reset");
                other_errors++;
            end
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (instr_req && !data_req && !illegal_instr) else begin
            $display("bus state is wrong in the first cycle after reset");
            other_errors++;
        end
        compare_word("first request", RESET_ADDR, {16'b0, instr_addr, 2'b00});

        cycles = 0;
        while (store_data.size() < exp_data.size() && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        assert (store_data.size() >= exp_data.size()) else begin
            $display("timeout with only %0d of %0d stores seen", store_data.size(),
                     exp_data.size());
            other_errors++;
        end
        // the program spins on its last jal, so a further store is a stray one.
        cycles = 0;
        while (store_data.size() == exp_data.size() && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        assert (store_data.size() <= exp_data.size()) else begin
            $display("a store appeared after the program had finished");
            other_errors++;
        end
        for (int i = 0; i < exp_data.size() && i < store_data.size(); i++) begin
            compare_word({exp_name[i], " address"}, exp_addr[i], store_addr[i]);
            compare_word(exp_name[i], exp_data[i], store_data[i]);
        end
        compare_word("illegal pulses", 32'd1, illegal_count);

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
logic/rv_pkg.sv
logic/rv_decode_if.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regs.sv
logic/rv_execute.sv
logic/rv_ctrl.sv
logic/rv_core.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module rv_core_tb -f rv_core.f -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
